//--- src.f
src/cpuPkg.sv
src/stageReg.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeUnit.sv
src/execUnit.sv
src/memArbiter.sv
src/hazardUnit.sv
src/cpuCore.sv
test/cpuTb_chk.sv
test/cpuTb.sv

//--- run.sh
#!/bin/sh
# build and run the cpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f src.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

out=$(./obj_dir/cpuSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

//--- test/cpuTb.sv
module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    localparam int KindAddu    = 0;
    localparam int KindSubu    = 1;
    localparam int KindAnd     = 2;
    localparam int KindOr      = 3;
    localparam int KindSlt     = 4;
    localparam int KindFwd     = 5;
    localparam int KindLoadUse = 6;
    localparam int KindBeqT    = 7;
    localparam int KindBeqN    = 8;
    localparam int KindBneT    = 9;
    localparam int KindBneN    = 10;
    localparam int KindR0      = 11;
    localparam int NumRows = 12;
    localparam int WaitLimit = 300;  // cycles allowed per wait loop
    localparam int DrainCycles = 12;

    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expVal;  // stored word or last retired value
    } caseRow_t;

    logic             clk = 1'b0;
    logic             rstN = 1'b0;
    logic [DataW-1:0] memRdata = '0;
    memReq_t          memReq;
    retire_t          retire;
    logic [31:0]      image [256];
    logic [31:0]      mem [256];
    memReq_t          seenReq = '0;   // request sampled mid-cycle
    logic             lastRead = 1'b0;
    logic [7:0]       lastIdx = '0;
    caseRow_t         rows [NumRows];
    retire_t          expQ [$];
    logic [31:0]      rng = 32'h42eb_5d7b;

    cpuCore UUT (
        .clk        (clk),
        .rstN_i     (rstN),
        .memReq_o   (memReq),
        .memRdata_i (memRdata),
        .retire_o   (retire)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // read word appears in the cycle after its strobe
    always @(negedge clk) begin
        memRdata <= lastRead ? mem[lastIdx] : '0;
        lastRead <= memReq.strobe && !memReq.we;
        lastIdx  <= memReq.addr[9:2];
        seenReq  <= memReq;
    end

    always @(posedge clk) begin
        if (!rstN) begin
            mem <= image;  // program image loaded while in reset
        end else if (seenReq.strobe && seenReq.we) begin
            mem[seenReq.addr[9:2]] <= seenReq.wdata;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] fn);
        return {OpRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [5:0] functFor(input int kind);
        case (kind)
            KindSubu: return FnSubu;
            KindAnd:  return FnAnd;
            KindOr:   return FnOr;
            KindSlt:  return FnSlt;
            default:  return FnAddu;
        endcase
    endfunction

    // wrap-around add and subtract and a signed compare
    function automatic logic [31:0] aluModel(input int kind, input logic [31:0] a,
                                             input logic [31:0] b);
        case (kind)
            KindSubu: return a - b;
            KindAnd:  return a & b;
            KindOr:   return a | b;
            KindSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  return a + b;
        endcase
    endfunction

    task automatic failRun(input string why);
        $display("%s at %0d ns", why, $time);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkEqual(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic addRetire(input logic [31:0] pc, input logic we, input logic [4:0] dest,
                             input logic [31:0] data);
        retire_t e;
        e.valid = 1'b1;
        e.pc    = pc;
        e.we    = we;
        e.dest  = dest;
        e.data  = data;
        expQ.push_back(e);
    endtask

    task automatic buildTable();
        logic [31:0] a16;
        logic [31:0] b16;
        for (int r = 0; r < NumRows; r++) begin
            rng = lcgNext(rng);
            rows[r].a = rng;
            rng = lcgNext(rng);
            rows[r].b = rng;
            rows[r].kind = 8'(r);
            a16 = sext16(rows[r].a[15:0]);
            b16 = sext16(rows[r].b[15:0]);
            case (r)
                KindFwd:     rows[r].expVal = 3 * a16 + 2 * b16;
                KindLoadUse: rows[r].expVal = 2 * rows[r].a + b16;
                KindR0:      rows[r].expVal = b16;
                KindBeqT, KindBeqN, KindBneT, KindBneN: rows[r].expVal = 32'd3;
                default:     rows[r].expVal = aluModel(r, rows[r].a, rows[r].b);
            endcase
        end
    endtask

    task automatic loadProgram(input caseRow_t row);
        logic [31:0] a16;
        logic [31:0] b16;
        logic [31:0] c;
        logic        taken;
        int          kind;
        kind = int'(row.kind);
        a16  = sext16(row.a[15:0]);
        b16  = sext16(row.b[15:0]);
        for (int i = 0; i < 256; i++) begin
            image[i] = {6'h3f, 26'(i) ^ 26'h15a_5a5a};  // unknown opcode decodes as a bubble
        end
        expQ.delete();
        case (kind)
            KindFwd: begin
                image[0] = encodeI(OpAddiu, 5'd0, 5'd1, row.a[15:0]);
                image[1] = encodeI(OpAddiu, 5'd1, 5'd2, row.b[15:0]);
                image[2] = encodeR(5'd2, 5'd1, 5'd3, FnAddu);
                image[3] = encodeR(5'd3, 5'd2, 5'd4, FnAddu);
                addRetire(32'd0, 1'b1, 5'd1, a16);
                addRetire(32'd4, 1'b1, 5'd2, a16 + b16);
                addRetire(32'd8, 1'b1, 5'd3, 2 * a16 + b16);
                addRetire(32'd12, 1'b1, 5'd4, row.expVal);
            end
            KindLoadUse: begin
                image[64] = row.a;
                image[0] = encodeI(OpLw, 5'd0, 5'd1, 16'h0100);
                image[1] = encodeR(5'd1, 5'd1, 5'd2, FnAddu);  // uses load in next slot
                image[2] = encodeI(OpAddiu, 5'd2, 5'd3, row.b[15:0]);
                addRetire(32'd0, 1'b1, 5'd1, row.a);
                addRetire(32'd4, 1'b1, 5'd2, 2 * row.a);
                addRetire(32'd8, 1'b1, 5'd3, row.expVal);
            end
            KindBeqT, KindBeqN, KindBneT, KindBneN: begin
                taken = (kind == KindBeqT) || (kind == KindBneT);
                c = (kind == KindBeqT || kind == KindBneN) ? a16 : (a16 ^ 32'd1);
                image[0] = encodeI(OpAddiu, 5'd0, 5'd1, row.a[15:0]);
                image[1] = encodeI(OpAddiu, 5'd0, 5'd2, c[15:0]);
                image[2] = encodeI((kind <= KindBeqN) ? OpBeq : OpBne, 5'd1, 5'd2, 16'd2);
                image[3] = encodeI(OpAddiu, 5'd0, 5'd3, 16'd1);
                image[4] = encodeI(OpAddiu, 5'd0, 5'd4, 16'd2);
                image[5] = encodeI(OpAddiu, 5'd0, 5'd5, 16'd3);
                addRetire(32'd0, 1'b1, 5'd1, a16);
                addRetire(32'd4, 1'b1, 5'd2, c);
                addRetire(32'd8, 1'b0, 5'd0, 32'd0);
                if (!taken) begin
                    addRetire(32'd12, 1'b1, 5'd3, 32'd1);
                    addRetire(32'd16, 1'b1, 5'd4, 32'd2);
                end
                addRetire(32'd20, 1'b1, 5'd5, row.expVal);
            end
            KindR0: begin
                image[0] = encodeI(OpAddiu, 5'd0, 5'd0, row.a[15:0]);
                image[1] = encodeR(5'd0, 5'd0, 5'd1, FnAddu);
                image[2] = encodeI(OpAddiu, 5'd1, 5'd2, row.b[15:0]);
                addRetire(32'd0, 1'b0, 5'd0, 32'd0);
                addRetire(32'd4, 1'b1, 5'd1, 32'd0);
                addRetire(32'd8, 1'b1, 5'd2, row.expVal);
            end
            default: begin  // load two words, combine, store result
                image[64] = row.a;
                image[65] = row.b;
                image[0] = encodeI(OpLw, 5'd0, 5'd1, 16'h0100);
                image[1] = encodeI(OpLw, 5'd0, 5'd2, 16'h0104);
                image[2] = encodeR(5'd1, 5'd2, 5'd3, functFor(kind));
                image[3] = encodeI(OpSw, 5'd0, 5'd3, 16'h0108);
                addRetire(32'd0, 1'b1, 5'd1, row.a);
                addRetire(32'd4, 1'b1, 5'd2, row.b);
                addRetire(32'd8, 1'b1, 5'd3, row.expVal);
                addRetire(32'd12, 1'b0, 5'd0, 32'd0);
            end
        endcase
    endtask

    task automatic checkRetire(input retire_t exp);
        checkEqual("retire pc", retire.pc, exp.pc);
        checkEqual("retire we", 32'(retire.we), 32'(exp.we));
        checkEqual("retire dest", 32'(retire.dest), 32'(exp.dest));
        if (exp.we) begin
            checkEqual("retire data", retire.data, exp.data);
        end
    endtask

    task automatic runRow(input caseRow_t row);
        int cycles;
        int got;
        rstN = 1'b0;
        loadProgram(row);
        repeat (16) begin
            @(negedge clk);
            checkEqual("strobe in reset", 32'(memReq.strobe), 32'd0);
            checkEqual("retire valid in reset", 32'(retire.valid), 32'd0);
        end
        rstN = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WaitLimit) begin
                failRun("no fetch strobe after reset release");
            end
        end while (!memReq.strobe);
        checkEqual("cycles to first fetch", 32'(cycles), 32'd1);
        checkEqual("first fetch address", memReq.addr, ResetPc);
        got = 0;
        cycles = 0;
        while (got < expQ.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > WaitLimit) begin
                failRun("expected retirement did not arrive");
            end
            if (retire.valid) begin
                checkRetire(expQ[got]);
                got++;
            end
        end
        // nothing may follow the last retirement
        repeat (DrainCycles) begin
            @(negedge clk);
            if (retire.valid) begin
                failRun("retirement beyond the end of the program");
            end
        end
        if (int'(row.kind) <= KindSlt) begin
            checkEqual("stored word", mem[66], row.expVal);
        end
    endtask

    initial begin
        buildTable();
        @(negedge clk);
        for (int r = 0; r < NumRows; r++) begin
            runRow(rows[r]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- test/cpuTb_chk.sv
module cpuTb_chk (
    input logic            clk,
    input logic            rstN_i,
    input cpuPkg::memReq_t memReq_i,
    input cpuPkg::retire_t retire_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // port stays quiet while reset is held
    noStrobeInReset: assert property (@(posedge clk) !rstN_i |-> !memReq_i.strobe)
        else $error("memory strobe seen during reset");

    wordAligned: assert property (@(posedge clk) disable iff (!rstN_i)
        memReq_i.strobe |-> memReq_i.addr[1:0] == 2'b00)
        else $error("memory strobe address not word aligned");

    // r0 writes must come out with we low
    noR0Write: assert property (@(posedge clk) disable iff (!rstN_i)
        (retire_i.valid && retire_i.we) |-> retire_i.dest != '0)
        else $error("retirement writes r0");

endmodule

bind cpuCore cpuTb_chk chk (
    .clk      (clk),
    .rstN_i   (rstN_i),
    .memReq_i (memReq_o),
    .retire_i (retire_o)
);

//--- src/cpuCore.sv
module cpuCore (
    input  logic                     clk,
    input  logic                     rstN_i,
    output cpuPkg::memReq_t          memReq_o,
    input  logic [cpuPkg::DataW-1:0] memRdata_i,
    output cpuPkg::retire_t          retire_o
);
    import cpuPkg::*;

    memReq_t          fetchReq;
    memReq_t          dataReq;
    logic             fetchLost;
    logic             fetchHold;
    logic [DataW-1:0] fetchRdata;
    logic [DataW-1:0] dataRdata;
    fetchDec_t        fetched;
    fetchDec_t        fdQ;
    decExe_t          decOut;
    decExe_t          deQ;
    exeMem_t          exeOut;
    exeMem_t          emQ;
    memWb_t           memOut;
    memWb_t           mwQ;
    fwdSel_t          fwdA;
    fwdSel_t          fwdB;
    logic             stallFd;
    logic             flushBr;
    logic             branchTaken;
    logic [DataW-1:0] branchTarget;

    assign fetchHold = stallFd | fetchLost;

    fetchUnit fetch (
        .clk(clk), .rstN_i(rstN_i),
        .hold_i(fetchHold), .redirect_i(flushBr), .target_i(branchTarget),
        .req_o(fetchReq), .instr_i(fetchRdata), .fetched_o(fetched)
    );

    memArbiter arb (
        .clk(clk), .rstN_i(rstN_i),
        .fetchReq_i(fetchReq), .dataReq_i(dataReq),
        .memReq_o(memReq_o), .fetchLost_o(fetchLost), .memRdata_i(memRdata_i),
        .fetchRdata_o(fetchRdata), .dataRdata_o(dataRdata)
    );

    stageReg #(.payload_t(fetchDec_t)) fdReg (
        .clk(clk), .rstN_i(rstN_i),
        .stall_i(stallFd), .flush_i(flushBr), .d_i(fetched), .q_o(fdQ)
    );

    decodeUnit decode (
        .clk(clk), .rstN_i(rstN_i), .inst_i(fdQ), .wb_i(mwQ), .dec_o(decOut)
    );

    // bubble into execute on a load-use stall or a taken branch
    stageReg #(.payload_t(decExe_t)) deReg (
        .clk(clk), .rstN_i(rstN_i),
        .stall_i(1'b0), .flush_i(stallFd | flushBr), .d_i(decOut), .q_o(deQ)
    );

    execUnit exec (
        .ex_i(deQ), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .memFwd_i(memOut.result), .wbFwd_i(mwQ.result),
        .ex_o(exeOut), .dataReq_o(dataReq),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget)
    );

    stageReg #(.payload_t(exeMem_t)) emReg (
        .clk(clk), .rstN_i(rstN_i),
        .stall_i(1'b0), .flush_i(1'b0), .d_i(exeOut), .q_o(emQ)
    );

    // load word arrives in the memory stage
    always_comb begin
        memOut.valid    = emQ.valid;
        memOut.pc       = emQ.pc;
        memOut.dest     = emQ.dest;
        memOut.regWrite = emQ.regWrite;
        memOut.result   = emQ.memRead ? dataRdata : emQ.aluResult;
    end

    stageReg #(.payload_t(memWb_t)) mwReg (
        .clk(clk), .rstN_i(rstN_i),
        .stall_i(1'b0), .flush_i(1'b0), .d_i(memOut), .q_o(mwQ)
    );

    hazardUnit hazard (
        .dec_i(deQ), .exe_i(emQ), .wb_i(mwQ),
        .decRs_i(fdQ.instr[25:21]), .decRt_i(fdQ.instr[20:16]),
        .branchTaken_i(branchTaken),
        .fwdA_o(fwdA), .fwdB_o(fwdB), .stallFd_o(stallFd), .flushBr_o(flushBr)
    );

    // retire report, same cycle as the register write
    always_comb begin
        retire_o.valid = mwQ.valid;
        retire_o.pc    = mwQ.pc;
        retire_o.we    = mwQ.regWrite;
        retire_o.dest  = mwQ.dest;
        retire_o.data  = mwQ.result;
    end

endmodule

//--- src/hazardUnit.sv
module hazardUnit (
    input  cpuPkg::decExe_t             dec_i,
    input  cpuPkg::exeMem_t             exe_i,
    input  cpuPkg::memWb_t              wb_i,
    input  logic [cpuPkg::RegAddrW-1:0] decRs_i,
    input  logic [cpuPkg::RegAddrW-1:0] decRt_i,
    input  logic                        branchTaken_i,
    output cpuPkg::fwdSel_t             fwdA_o,
    output cpuPkg::fwdSel_t             fwdB_o,
    output logic                        stallFd_o,
    output logic                        flushBr_o
);
    import cpuPkg::*;

    logic loadInExe;

    // memory stage is younger, so it wins over writeback
    function automatic fwdSel_t pickSource(
        input logic [RegAddrW-1:0] src,
        input exeMem_t             exe,
        input memWb_t              wb
    );
        if (exe.valid && exe.regWrite && exe.dest == src) begin
            return FwdMem;
        end
        if (wb.valid && wb.regWrite && wb.dest == src) begin
            return FwdWb;
        end
        return FwdReg;
    endfunction

    assign fwdA_o = pickSource(dec_i.rs, exe_i, wb_i);
    assign fwdB_o = pickSource(dec_i.rt, exe_i, wb_i);

    assign loadInExe = dec_i.valid & dec_i.memRead & (dec_i.dest != '0);
    assign stallFd_o = loadInExe & ((dec_i.dest == decRs_i) | (dec_i.dest == decRt_i));

    assign flushBr_o = branchTaken_i;  // resolved in execute

endmodule

//--- src/memArbiter.sv
module memArbiter (
    input  logic                     clk,
    input  logic                     rstN_i,
    input  cpuPkg::memReq_t          fetchReq_i,
    input  cpuPkg::memReq_t          dataReq_i,
    output cpuPkg::memReq_t          memReq_o,
    output logic                     fetchLost_o,
    input  logic [cpuPkg::DataW-1:0] memRdata_i,
    output logic [cpuPkg::DataW-1:0] fetchRdata_o,
    output logic [cpuPkg::DataW-1:0] dataRdata_o
);

    logic dataOwned;  // last cycle's read came from the data side

    // data access always wins the port
    assign memReq_o    = dataReq_i.strobe ? dataReq_i : fetchReq_i;
    assign fetchLost_o = dataReq_i.strobe;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            dataOwned <= 1'b0;
        end else begin
            dataOwned <= dataReq_i.strobe & ~dataReq_i.we;
        end
    end

    // read word lands one cycle after its strobe
    assign fetchRdata_o = dataOwned ? '0 : memRdata_i;
    assign dataRdata_o  = dataOwned ? memRdata_i : '0;

endmodule

//--- src/execUnit.sv
module execUnit (
    input  cpuPkg::decExe_t          ex_i,
    input  cpuPkg::fwdSel_t          fwdA_i,
    input  cpuPkg::fwdSel_t          fwdB_i,
    input  logic [cpuPkg::DataW-1:0] memFwd_i,
    input  logic [cpuPkg::DataW-1:0] wbFwd_i,
    output cpuPkg::exeMem_t          ex_o,
    output cpuPkg::memReq_t          dataReq_o,
    output logic                     branchTaken_o,
    output logic [cpuPkg::DataW-1:0] branchTarget_o
);
    import cpuPkg::*;

    logic [DataW-1:0] opA;
    logic [DataW-1:0] opB;
    logic [DataW-1:0] aluB;
    logic [DataW-1:0] aluResult;

    function automatic logic [DataW-1:0] pickOperand(
        input fwdSel_t          sel,
        input logic [DataW-1:0] regVal,
        input logic [DataW-1:0] memVal,
        input logic [DataW-1:0] wbVal
    );
        case (sel)
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA  = pickOperand(fwdA_i, ex_i.regA, memFwd_i, wbFwd_i);
    assign opB  = pickOperand(fwdB_i, ex_i.regB, memFwd_i, wbFwd_i);
    assign aluB = ex_i.useImm ? ex_i.imm : opB;

    always_comb begin
        case (ex_i.aluOp)
            AluSub:  aluResult = opA - aluB;
            AluAnd:  aluResult = opA & aluB;
            AluOr:   aluResult = opA | aluB;
            AluSlt:  aluResult = {{(DataW-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluResult = opA + aluB;  // also load/store address
        endcase
    end

    assign branchTaken_o = ex_i.valid
        & ((ex_i.isBeq & (opA == opB)) | (ex_i.isBne & (opA != opB)));
    assign branchTarget_o = ex_i.pc + DataW'(4) + {ex_i.imm[DataW-3:0], 2'b00};

    always_comb begin
        dataReq_o.strobe = ex_i.valid & (ex_i.memRead | ex_i.memWrite);
        dataReq_o.we     = ex_i.memWrite;
        dataReq_o.addr   = aluResult;
        dataReq_o.wdata  = opB;  // store data follows forwarding too

        ex_o.valid     = ex_i.valid;
        ex_o.pc        = ex_i.pc;
        ex_o.dest      = ex_i.dest;
        ex_o.regWrite  = ex_i.regWrite;
        ex_o.memRead   = ex_i.memRead;
        ex_o.aluResult = aluResult;
    end

endmodule

//--- src/decodeUnit.sv
module decodeUnit (
    input  logic              clk,
    input  logic              rstN_i,
    input  cpuPkg::fetchDec_t inst_i,
    input  cpuPkg::memWb_t    wb_i,
    output cpuPkg::decExe_t   dec_o
);
    import cpuPkg::*;

    logic [5:0]          opcode;
    logic [5:0]          funct;
    logic [RegAddrW-1:0] rs;
    logic [RegAddrW-1:0] rt;
    logic [RegAddrW-1:0] rd;
    logic [DataW-1:0]    rdataA;
    logic [DataW-1:0]    rdataB;
    logic                known;  // opcode and funct both recognised

    assign opcode = inst_i.instr[31:26];
    assign rs     = inst_i.instr[25:21];
    assign rt     = inst_i.instr[20:16];
    assign rd     = inst_i.instr[15:11];
    assign funct  = inst_i.instr[5:0];

    regFile rf (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .raddrA_i (rs),
        .raddrB_i (rt),
        .rdataA_o (rdataA),
        .rdataB_o (rdataB),
        .we_i     (wb_i.valid & wb_i.regWrite),
        .waddr_i  (wb_i.dest),
        .wdata_i  (wb_i.result)
    );

    always_comb begin
        dec_o       = '0;
        known       = 1'b1;
        dec_o.pc    = inst_i.pc;
        dec_o.rs    = rs;
        dec_o.rt    = rt;
        dec_o.regA  = rdataA;
        dec_o.regB  = rdataB;
        dec_o.imm   = {{(DataW-16){inst_i.instr[15]}}, inst_i.instr[15:0]};
        dec_o.aluOp = AluAdd;
        case (opcode)
            OpRtype: begin
                dec_o.dest     = rd;
                dec_o.regWrite = 1'b1;
                case (funct)
                    FnAddu:  dec_o.aluOp = AluAdd;
                    FnSubu:  dec_o.aluOp = AluSub;
                    FnAnd:   dec_o.aluOp = AluAnd;
                    FnOr:    dec_o.aluOp = AluOr;
                    FnSlt:   dec_o.aluOp = AluSlt;
                    default: known = 1'b0;  // also catches the all-zero nop
                endcase
            end
            OpAddiu: begin
                dec_o.dest     = rt;
                dec_o.useImm   = 1'b1;
                dec_o.regWrite = 1'b1;
            end
            OpLw: begin
                dec_o.dest     = rt;
                dec_o.useImm   = 1'b1;
                dec_o.regWrite = 1'b1;
                dec_o.memRead  = 1'b1;
            end
            OpSw: begin
                dec_o.useImm   = 1'b1;
                dec_o.memWrite = 1'b1;
            end
            OpBeq:   dec_o.isBeq = 1'b1;
            OpBne:   dec_o.isBne = 1'b1;
            default: known = 1'b0;
        endcase
        dec_o.valid = inst_i.valid & known;
        if (dec_o.dest == '0) begin
            dec_o.regWrite = 1'b0;  // r0 stays zero
        end
        if (!dec_o.valid) begin
            dec_o = '0;
        end
    end

endmodule

//--- src/regFile.sv
module regFile (
    input  logic                        clk,
    input  logic                        rstN_i,
    input  logic [cpuPkg::RegAddrW-1:0] raddrA_i,
    input  logic [cpuPkg::RegAddrW-1:0] raddrB_i,
    output logic [cpuPkg::DataW-1:0]    rdataA_o,
    output logic [cpuPkg::DataW-1:0]    rdataB_o,
    input  logic                        we_i,
    input  logic [cpuPkg::RegAddrW-1:0] waddr_i,
    input  logic [cpuPkg::DataW-1:0]    wdata_i
);
    import cpuPkg::*;

    logic [DataW-1:0] regs [1 << RegAddrW];
    logic             wrLive;  // a real write this cycle

    assign wrLive = we_i && (waddr_i != '0);

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < (1 << RegAddrW); i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[waddr_i] <= wdata_i;  // r0 never written
        end
    end

    // same-cycle write passes straight to the read ports
    assign rdataA_o = (wrLive && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (wrLive && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

//--- src/fetchUnit.sv
module fetchUnit (
    input  logic                     clk,
    input  logic                     rstN_i,
    input  logic                     hold_i,
    input  logic                     redirect_i,
    input  logic [cpuPkg::DataW-1:0] target_i,
    output cpuPkg::memReq_t          req_o,
    input  logic [cpuPkg::DataW-1:0] instr_i,
    output cpuPkg::fetchDec_t        fetched_o
);
    import cpuPkg::*;

    logic             running;   // set at the first edge after reset release
    logic [DataW-1:0] pc;
    logic             reqValid;  // a read went out last cycle
    logic [DataW-1:0] reqPc;     // pc of that read

    always_comb begin
        req_o        = '0;
        req_o.strobe = running & ~hold_i;
        req_o.addr   = pc;
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            running  <= 1'b0;
            pc       <= ResetPc;
            reqValid <= 1'b0;
            reqPc    <= ResetPc;
        end else begin
            running <= 1'b1;
            if (redirect_i) begin
                pc       <= target_i;
                reqValid <= 1'b0;  // word in flight is on the wrong path
            end else if (hold_i) begin
                // returning word is dropped and fetched again later
                if (reqValid) begin
                    pc <= reqPc;
                end
                reqValid <= 1'b0;
            end else if (running) begin
                pc       <= pc + DataW'(4);
                reqValid <= 1'b1;
                reqPc    <= pc;
            end
        end
    end

    // pair the returning word with its pc
    always_comb begin
        fetched_o = '0;
        if (reqValid && !hold_i) begin
            fetched_o.valid = 1'b1;
            fetched_o.pc    = reqPc;
            fetched_o.instr = instr_i;
        end
    end

endmodule

//--- src/stageReg.sv
module stageReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // an all-zero payload is a bubble since valid is low
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

    localparam int DataW    = 32;
    localparam int RegAddrW = 5;

    localparam logic [DataW-1:0] ResetPc = '0;  // first fetch address

    // primary opcodes
    localparam logic [5:0] OpRtype = 6'h00;
    localparam logic [5:0] OpAddiu = 6'h09;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSw    = 6'h2b;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;

    // function codes of the R-type group
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt  // signed compare
    } aluOp_t;

    typedef enum logic [1:0] {
        FwdReg = 2'd0,  // value read in decode
        FwdMem = 2'd1,
        FwdWb  = 2'd2
    } fwdSel_t;

    typedef struct packed {
        logic             valid;
        logic [DataW-1:0] pc;
        logic [DataW-1:0] instr;
    } fetchDec_t;

    typedef struct packed {
        logic                valid;
        logic [DataW-1:0]    pc;
        logic [RegAddrW-1:0] rs;
        logic [RegAddrW-1:0] rt;
        logic [RegAddrW-1:0] dest;
        logic [DataW-1:0]    regA;
        logic [DataW-1:0]    regB;
        logic [DataW-1:0]    imm;     // sign extended
        aluOp_t              aluOp;
        logic                useImm;
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic                isBeq;
        logic                isBne;
    } decExe_t;

    typedef struct packed {
        logic                valid;
        logic [DataW-1:0]    pc;
        logic [RegAddrW-1:0] dest;
        logic                regWrite;
        logic                memRead;
        logic [DataW-1:0]    aluResult;  // address for loads and stores
    } exeMem_t;

    typedef struct packed {
        logic                valid;
        logic [DataW-1:0]    pc;
        logic [RegAddrW-1:0] dest;
        logic                regWrite;
        logic [DataW-1:0]    result;
    } memWb_t;

    typedef struct packed {
        logic             strobe;
        logic             we;
        logic [DataW-1:0] addr;
        logic [DataW-1:0] wdata;
    } memReq_t;

    typedef struct packed {
        logic                valid;
        logic [DataW-1:0]    pc;
        logic                we;
        logic [RegAddrW-1:0] dest;
        logic [DataW-1:0]    data;
    } retire_t;

endpackage
